// File: verilog/exec_pkg.sv
package exec_pkg;

    localparam int xlen = 32;
    localparam int alen = 32;

    localparam int mul_cycles = 32; // one multiplier bit per cycle.

    localparam logic [3:0] cause_instr_misaligned = 4'd0;
    localparam logic [3:0] cause_illegal_instr = 4'd2;

    // instruction bits 6:2.
    typedef enum logic [4:0] {
        op_imm = 5'b00100,
        auipc  = 5'b00101,
        op     = 5'b01100,
        lui    = 5'b01101,
        branch = 5'b11000,
        jalr   = 5'b11001,
        jal    = 5'b11011
    } opcode_t;

    typedef enum logic [2:0] {
        f_add  = 3'd0,
        f_sll  = 3'd1,
        f_slt  = 3'd2,
        f_sltu = 3'd3,
        f_xor  = 3'd4,
        f_sr   = 3'd5,
        f_or   = 3'd6,
        f_and  = 3'd7
    } alu_funct3_t;

    typedef enum logic [2:0] {
        beq  = 3'd0,
        bne  = 3'd1,
        blt  = 3'd4,
        bge  = 3'd5,
        bltu = 3'd6,
        bgeu = 3'd7
    } br_funct3_t;

    // owner of the pending output record.
    typedef enum logic [1:0] {
        unit_none   = 2'd0,
        unit_int    = 2'd1,
        unit_branch = 2'd2
    } unit_t;

endpackage

// File: verilog/exec_int.sv
`timescale 1ns/10ps

module exec_int (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      int_start,
    input  exec_pkg::opcode_t         opcode,
    input  logic [2:0]                funct3,
    input  logic [6:0]                funct7,
    input  logic [exec_pkg::xlen-1:0] op_a,
    input  logic [exec_pkg::xlen-1:0] op_b,
    input  logic [exec_pkg::xlen-1:0] imm,
    input  logic [exec_pkg::alen-1:0] instr_addr,
    output logic                      int_done,
    output logic                      int_busy,
    output logic                      int_exception,
    output logic [3:0]                int_trap_cause,
    output logic [exec_pkg::xlen-1:0] int_result
);
    import exec_pkg::*;

    typedef enum logic [1:0] {
        idle,
        mult,
        done
    } mul_state_t;

    mul_state_t state;
    alu_funct3_t f3;
    logic [xlen-1:0] src_b;
    logic [4:0] shamt;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] value;
    logic is_mul;
    logic bad_funct7;
    logic illegal;
    logic [xlen-1:0] mcand;
    logic [xlen-1:0] mplier;
    logic [$clog2(mul_cycles)-1:0] count;

    always_comb begin
        f3 = alu_funct3_t'(funct3);
        src_b = (opcode == op) ? op_b : imm;
        shamt = src_b[4:0];
        case (f3)
            f_add: begin
                if (opcode == op && funct7[5]) begin
                    alu_out = op_a - src_b; // sub.
                end else begin
                    alu_out = op_a + src_b;
                end
            end
            f_sll: alu_out = op_a << shamt;
            f_slt: alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            f_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < src_b};
            f_xor: alu_out = op_a ^ src_b;
            f_sr: begin
                if (funct7[5]) begin
                    alu_out = $signed(op_a) >>> shamt;
                end else begin
                    alu_out = op_a >> shamt;
                end
            end
            f_or: alu_out = op_a | src_b;
            default: alu_out = op_a & src_b;
        endcase

        case (opcode)
            op, op_imm: value = alu_out;
            lui: value = imm;
            auipc: value = xlen'(instr_addr) + imm;
            default: value = '0;
        endcase

        is_mul = opcode == op && funct7 == 7'b0000001 && f3 == f_add;
        bad_funct7 = opcode == op && !(funct7 == 7'b0000000 || is_mul ||
                     (funct7 == 7'b0100000 && (f3 == f_add || f3 == f_sr)));
        illegal = bad_funct7 || !(opcode inside {op, op_imm, lui, auipc});
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            int_done <= 1'b0;
            int_exception <= 1'b0;
        end else begin
            case (state)
                mult: begin
                    if (count == $bits(count)'(mul_cycles - 1)) begin
                        state <= done;
                        int_done <= 1'b1;
                    end
                end
                default: begin // idle and done both take a new start.
                    state <= (int_start && is_mul) ? mult : idle;
                    int_done <= int_start && !is_mul;
                    if (int_start) begin
                        int_exception <= illegal;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mult) begin
            if (mplier[0]) begin
                int_result <= int_result + mcand;
            end
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
            count <= count + 1'b1;
        end else if (int_start) begin
            int_result <= is_mul ? '0 : value;
            mcand <= op_a;
            mplier <= op_b;
            count <= '0;
        end
    end

    assign int_busy = state == mult;
    assign int_trap_cause = cause_illegal_instr; // only trap this unit raises.

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst) int_start |-> !int_busy
    );

endmodule

// File: verilog/exec_branch.sv
`timescale 1ns/10ps

module exec_branch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      branch_start,
    input  exec_pkg::opcode_t         opcode,
    input  logic [2:0]                funct3,
    input  logic [exec_pkg::xlen-1:0] op_a,
    input  logic [exec_pkg::xlen-1:0] op_b,
    input  logic [exec_pkg::xlen-1:0] imm,
    input  logic [exec_pkg::alen-1:0] instr_addr,
    input  logic [exec_pkg::alen-1:0] next_addr,
    output logic                      branch_done,
    output logic                      branch_taken,
    output logic                      branch_exception,
    output logic [3:0]                branch_trap_cause,
    output logic [exec_pkg::alen-1:0] branch_target,
    output logic [exec_pkg::xlen-1:0] branch_result
);
    import exec_pkg::*;

    logic cmp;
    logic bad_funct3;
    logic taken;
    logic misaligned;
    logic illegal;
    logic [alen-1:0] target;

    always_comb begin
        bad_funct3 = 1'b0;
        case (br_funct3_t'(funct3))
            beq: cmp = op_a == op_b;
            bne: cmp = op_a != op_b;
            blt: cmp = $signed(op_a) < $signed(op_b);
            bge: cmp = $signed(op_a) >= $signed(op_b);
            bltu: cmp = op_a < op_b;
            bgeu: cmp = op_a >= op_b;
            default: begin
                cmp = 1'b0;
                bad_funct3 = 1'b1;
            end
        endcase

        illegal = opcode == branch && bad_funct3;
        taken = opcode == jal || opcode == jalr || (opcode == branch && cmp);

        if (opcode == jalr) begin
            target = alen'(op_a + imm) & ~alen'(1);
        end else begin
            target = instr_addr + alen'(imm);
        end
        misaligned = taken && target[1:0] != 2'b00;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branch_done <= 1'b0;
            branch_taken <= 1'b0;
            branch_exception <= 1'b0;
        end else begin
            branch_done <= branch_start;
            if (branch_start) begin
                branch_taken <= taken && !misaligned && !illegal;
                branch_exception <= misaligned || illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (branch_start) begin
            branch_trap_cause <= illegal ? cause_illegal_instr : cause_instr_misaligned;
            branch_target <= target;
            branch_result <= xlen'(next_addr); // link value.
        end
    end

    // a redirecting result kills the instruction offered with it.
    a_no_start_on_redirect: assert property (
        @(posedge clk) disable iff (rst)
            branch_done && (branch_taken || branch_exception) |-> !branch_start
    );

endmodule

// File: verilog/exec_control.sv
`timescale 1ns/10ps

module exec_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      prev_stalled,
    output logic                      stall_prev,
    output logic                      stall_next,
    input  exec_pkg::opcode_t         opcode,
    input  logic [4:0]                rd,
    input  logic [4:0]                rs1,
    input  logic [4:0]                rs2,
    input  logic                      is_reg_write,
    input  logic [exec_pkg::xlen-1:0] rs1_data,
    input  logic [exec_pkg::xlen-1:0] rs2_data,
    output logic [exec_pkg::xlen-1:0] op_a,
    output logic [exec_pkg::xlen-1:0] op_b,
    output logic                      int_start,
    output logic                      branch_start,
    input  logic                      int_done,
    input  logic                      int_busy,
    input  logic                      int_exception,
    input  logic [3:0]                int_trap_cause,
    input  logic [exec_pkg::xlen-1:0] int_result,
    input  logic                      branch_done,
    input  logic                      branch_taken,
    input  logic                      branch_exception,
    input  logic [3:0]                branch_trap_cause,
    input  logic [exec_pkg::alen-1:0] branch_target,
    input  logic [exec_pkg::xlen-1:0] branch_result,
    output logic [exec_pkg::xlen-1:0] exec_result,
    output logic                      exec_is_reg_write,
    output logic [4:0]                exec_reg_write_sel,
    output logic                      exec_exception,
    output logic [3:0]                exec_trap_cause,
    output logic                      exec_is_taken_branch,
    output logic [exec_pkg::alen-1:0] exec_branch_target,
    output logic                      exec_mispredict_detected,
    output logic [exec_pkg::alen-1:0] exec_mispredict_next_pc,
    output logic                      exec_pipeline_flush
);
    import exec_pkg::*;

    unit_t owner;
    logic pend_wr;
    logic [4:0] pend_rd;
    logic input_valid;
    logic is_branch_op;
    logic unit_exception;

    // one-deep bypass from the output record.
    assign op_a = (exec_is_reg_write && exec_reg_write_sel == rs1) ? exec_result : rs1_data;
    assign op_b = (exec_is_reg_write && exec_reg_write_sel == rs2) ? exec_result : rs2_data;

    assign stall_prev = int_busy;
    assign input_valid = !prev_stalled && !stall_prev && !exec_pipeline_flush;
    assign is_branch_op = opcode inside {jal, jalr, branch};
    assign int_start = input_valid && !is_branch_op; // unknown opcodes trap in exec_int.
    assign branch_start = input_valid && is_branch_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= unit_none;
            pend_wr <= 1'b0;
            pend_rd <= 5'd0;
        end else if (input_valid) begin
            owner <= is_branch_op ? unit_branch : unit_int;
            pend_wr <= is_reg_write && rd != 5'd0;
            pend_rd <= is_reg_write ? rd : 5'd0;
        end else if (!stall_next) begin
            owner <= unit_none;
            pend_wr <= 1'b0;
            pend_rd <= 5'd0;
        end
    end

    always_comb begin
        case (owner)
            unit_int: begin
                exec_result = int_result;
                unit_exception = int_exception;
                exec_trap_cause = int_trap_cause;
            end
            unit_branch: begin
                exec_result = branch_result;
                unit_exception = branch_exception;
                exec_trap_cause = branch_trap_cause;
            end
            default: begin
                exec_result = '0;
                unit_exception = 1'b0;
                exec_trap_cause = 4'd0;
            end
        endcase
    end

    assign stall_next = !(int_done || branch_done);
    assign exec_exception = !stall_next && unit_exception;
    assign exec_is_reg_write = !stall_next && pend_wr && !unit_exception;
    assign exec_reg_write_sel = pend_rd;
    assign exec_is_taken_branch = !stall_next && owner == unit_branch && branch_taken;
    assign exec_branch_target = branch_target;

    // static not-taken prediction.
    assign exec_mispredict_detected = exec_is_taken_branch;
    assign exec_mispredict_next_pc = exec_branch_target;
    assign exec_pipeline_flush = exec_mispredict_detected || exec_exception;

    a_one_unit_done: assert property (
        @(posedge clk) disable iff (rst) !(int_done && branch_done)
    );

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      prev_stalled,
    output logic                      stall_prev,
    output logic                      stall_next,
    input  exec_pkg::opcode_t         opcode,
    input  logic [2:0]                funct3,
    input  logic [6:0]                funct7,
    input  logic [4:0]                rd,
    input  logic [4:0]                rs1,
    input  logic [4:0]                rs2,
    input  logic [exec_pkg::xlen-1:0] rs1_data,
    input  logic [exec_pkg::xlen-1:0] rs2_data,
    input  logic [exec_pkg::xlen-1:0] imm,
    input  logic [exec_pkg::alen-1:0] instr_addr,
    input  logic [exec_pkg::alen-1:0] next_addr,
    input  logic                      is_reg_write,
    output logic [exec_pkg::xlen-1:0] exec_result,
    output logic                      exec_is_reg_write,
    output logic [4:0]                exec_reg_write_sel,
    output logic                      exec_exception,
    output logic [3:0]                exec_trap_cause,
    output logic                      exec_is_taken_branch,
    output logic [exec_pkg::alen-1:0] exec_branch_target,
    output logic                      exec_mispredict_detected,
    output logic [exec_pkg::alen-1:0] exec_mispredict_next_pc,
    output logic                      exec_pipeline_flush
);
    import exec_pkg::*;

    logic [xlen-1:0] op_a; // forwarded operands.
    logic [xlen-1:0] op_b;
    logic int_start;
    logic int_done;
    logic int_busy;
    logic int_exception;
    logic [3:0] int_trap_cause;
    logic [xlen-1:0] int_result;
    logic branch_start;
    logic branch_done;
    logic branch_taken;
    logic branch_exception;
    logic [3:0] branch_trap_cause;
    logic [alen-1:0] branch_target;
    logic [xlen-1:0] branch_result;

    exec_int exec_int_i (
        .clk,
        .rst,
        .int_start,
        .opcode,
        .funct3,
        .funct7,
        .op_a,
        .op_b,
        .imm,
        .instr_addr,
        .int_done,
        .int_busy,
        .int_exception,
        .int_trap_cause,
        .int_result
    );

    exec_branch exec_branch_i (
        .clk,
        .rst,
        .branch_start,
        .opcode,
        .funct3,
        .op_a,
        .op_b,
        .imm,
        .instr_addr,
        .next_addr,
        .branch_done,
        .branch_taken,
        .branch_exception,
        .branch_trap_cause,
        .branch_target,
        .branch_result
    );

    exec_control exec_control_i (
        .clk,
        .rst,
        .prev_stalled,
        .stall_prev,
        .stall_next,
        .opcode,
        .rd,
        .rs1,
        .rs2,
        .is_reg_write,
        .rs1_data,
        .rs2_data,
        .op_a,
        .op_b,
        .int_start,
        .branch_start,
        .int_done,
        .int_busy,
        .int_exception,
        .int_trap_cause,
        .int_result,
        .branch_done,
        .branch_taken,
        .branch_exception,
        .branch_trap_cause,
        .branch_target,
        .branch_result,
        .exec_result,
        .exec_is_reg_write,
        .exec_reg_write_sel,
        .exec_exception,
        .exec_trap_cause,
        .exec_is_taken_branch,
        .exec_branch_target,
        .exec_mispredict_detected,
        .exec_mispredict_next_pc,
        .exec_pipeline_flush
    );

endmodule

// File: verification/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// expected output record of one accepted instruction.
typedef struct packed {
    logic [xlen-1:0] result;
    logic            wr;
    logic [4:0]      rd;
    logic            exc;
    logic [3:0]      cause;
    logic            taken;
    logic [alen-1:0] target;
} exp_rec_t;

logic [31:0] lfsr = 32'h2378_d8d4;
logic fwd_wr = 1'b0; // model copy of the bypass register.
logic [4:0] fwd_rd = 5'd0;
logic [xlen-1:0] fwd_val = '0;
logic flush_now = 1'b0;

// galois lfsr stepped once per bit; the first bit taken is the most significant.
function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
endfunction

function automatic logic [xlen-1:0] bypass(logic [4:0] rs, logic [xlen-1:0] data);
    return (fwd_wr && fwd_rd == rs) ? fwd_val : data;
endfunction

function automatic void retire(exp_rec_t r);
    fwd_wr = r.wr;
    fwd_rd = r.rd;
    fwd_val = r.result;
    flush_now = r.taken || r.exc; // kills the instruction offered in this cycle.
endfunction

function automatic void clear_bypass();
    fwd_wr = 1'b0;
    flush_now = 1'b0;
endfunction

function automatic exp_rec_t predict(opcode_t opc, logic [2:0] f3, logic [6:0] f7,
        logic [xlen-1:0] a, logic [xlen-1:0] b, logic [xlen-1:0] imm,
        logic [alen-1:0] pc, logic [alen-1:0] npc, logic wr_en, logic [4:0] rd);
    exp_rec_t r;
    logic [xlen-1:0] src;
    logic cond;
    r = '0;
    src = (opc == op) ? b : imm;
    r.cause = cause_illegal_instr;
    case (opc)
        lui: r.result = imm;
        auipc: r.result = pc + imm;
        jal, jalr, branch: begin
            r.result = npc; // link value.
            r.target = (opc == jalr) ? ((a + imm) & ~32'd1) : pc + imm;
            case (br_funct3_t'(f3))
                beq: cond = a == b;
                bne: cond = a != b;
                blt: cond = $signed(a) < $signed(b);
                bge: cond = $signed(a) >= $signed(b);
                bltu: cond = a < b;
                default: cond = a >= b;
            endcase
            if (opc == branch && f3 inside {3'd2, 3'd3}) begin
                r.exc = 1'b1;
            end else if (opc != branch || cond) begin
                r.exc = r.target[1:0] != 2'b00;
                r.taken = !r.exc;
                r.cause = cause_instr_misaligned;
            end
        end
        default: begin
            if (opc == op && f7 == 7'h01 && f3 == 3'd0) begin
                r.result = a * b; // low word only.
            end else if (opc == op && f7 != 7'h00 &&
                         !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                r.exc = 1'b1;
            end else begin
                case (alu_funct3_t'(f3))
                    f_add: r.result = (opc == op && f7[5]) ? a - src : a + src;
                    f_sll: r.result = a << src[4:0];
                    f_slt: r.result = {31'd0, $signed(a) < $signed(src)};
                    f_sltu: r.result = {31'd0, a < src};
                    f_xor: r.result = a ^ src;
                    f_sr: begin
                        if (f7[5]) begin
                            r.result = $signed(a) >>> src[4:0]; // sign fill.
                        end else begin
                            r.result = a >> src[4:0];
                        end
                    end
                    f_or: r.result = a | src;
                    default: r.result = a & src;
                endcase
            end
        end
    endcase
    r.rd = rd;
    r.wr = wr_en && rd != 5'd0 && !r.exc;
    return r;
endfunction

`endif

// File: verification/exec_stage_tb.sv
`timescale 1ns/10ps

module exec_stage_tb;
    import exec_pkg::*;

    localparam int num_instr = 500;
    localparam int watchdog_cycles = num_instr * mul_cycles + 40;

    logic clk;
    logic rst;
    logic prev_stalled;
    logic stall_prev;
    logic stall_next;
    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [alen-1:0] instr_addr;
    logic [alen-1:0] next_addr;
    logic is_reg_write;
    logic [xlen-1:0] exec_result;
    logic exec_is_reg_write;
    logic [4:0] exec_reg_write_sel;
    logic exec_exception;
    logic [3:0] exec_trap_cause;
    logic exec_is_taken_branch;
    logic [alen-1:0] exec_branch_target;
    logic exec_mispredict_detected;
    logic [alen-1:0] exec_mispredict_next_pc;
    logic exec_pipeline_flush;

    int errors = 0;
    int checks = 0;
    int accepted = 0;
    int retired = 0;

    `include "exec_model.svh"

    exp_rec_t exp_q[$];
    logic due_now = 1'b0; // single-cycle result due in this cycle.
    logic mul_pending = 1'b0;

    exec_stage exec_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_record(exp_rec_t r);
        check("stall_next", 32'(stall_next), 32'd0);
        check("reg write", 32'(exec_is_reg_write), 32'(r.wr));
        if (r.wr) begin
            check("write select", 32'(exec_reg_write_sel), 32'(r.rd));
        end
        check("exception", 32'(exec_exception), 32'(r.exc));
        if (r.exc) begin
            check("trap cause", 32'(exec_trap_cause), 32'(r.cause));
        end else begin
            check("result", exec_result, r.result);
        end
        check("taken", 32'(exec_is_taken_branch), 32'(r.taken));
        check("mispredict", 32'(exec_mispredict_detected), 32'(r.taken));
        if (r.taken) begin
            check("branch target", exec_branch_target, r.target);
            check("next pc", exec_mispredict_next_pc, r.target);
        end
        check("flush", 32'(exec_pipeline_flush), 32'(r.taken || r.exc));
    endtask

    task automatic check_cycle();
        exp_rec_t r;
        if (due_now || (mul_pending && !stall_next)) begin
            r = exp_q.pop_front();
            compare_record(r);
            retire(r);
            retired++;
            due_now = 1'b0;
            mul_pending = 1'b0;
        end else begin
            check("stall_next", 32'(stall_next), 32'd1);
            check("reg write", 32'(exec_is_reg_write), 32'd0);
            check("flush", 32'(exec_pipeline_flush), 32'd0);
            clear_bypass();
        end
        check("stall_prev", 32'(stall_prev), 32'(mul_pending));
    endtask

    task automatic offer_instr();
        logic [2:0] pick;
        logic [2:0] f7_pick;
        logic [31:0] raw;
        logic is_mul;
        prev_stalled = take_bits(3) == 0;
        if (accepted >= num_instr) begin
            prev_stalled = 1'b1;
        end
        pick = 3'(take_bits(3));
        case (pick)
            3'd0: opcode = op_imm;
            3'd1, 3'd2: opcode = op;
            3'd3: opcode = lui;
            3'd4: opcode = auipc;
            3'd5: opcode = jal;
            3'd6: opcode = jalr;
            default: opcode = branch;
        endcase
        funct3 = 3'(take_bits(3));
        f7_pick = 3'(take_bits(3));
        if (opcode == op_imm) begin
            funct7 = f7_pick[0] ? 7'h20 : 7'h00;
        end else if (f7_pick < 3'd3) begin
            funct7 = 7'h00;
        end else if (f7_pick < 3'd5) begin
            funct7 = 7'h20;
        end else if (f7_pick < 3'd7) begin
            funct7 = 7'h01;
            if (take_bits(1) != 0) begin
                funct3 = 3'd0; // bias toward mul.
            end
        end else begin
            funct7 = 7'(take_bits(7));
        end
        if (opcode inside {jal, jalr}) begin
            funct3 = 3'd0;
        end
        if (opcode inside {lui, auipc}) begin
            imm = {20'(take_bits(20)), 12'd0};
        end else begin
            raw = take_bits(13);
            imm = {{19{raw[12]}}, raw[12:0]};
            if (take_bits(3) != 0) begin
                imm[1:0] = 2'b00;
            end
        end
        rd = 5'(take_bits(3)); // few registers, so bypass hits often.
        rs1 = 5'(take_bits(3));
        rs2 = 5'(take_bits(3));
        rs1_data = take_bits(32);
        rs2_data = take_bits(32);
        if (take_bits(2) == 0) begin
            rs2_data = rs1_data;
        end
        if (opcode == jalr && take_bits(2) != 0) begin
            rs1_data[1:0] = 2'b00;
        end
        instr_addr = {30'(take_bits(30)), 2'b00};
        next_addr = instr_addr + 32'd4;
        is_reg_write = take_bits(3) != 0;

        if (!prev_stalled && !mul_pending && !flush_now) begin
            is_mul = opcode == op && funct7 == 7'h01 && funct3 == 3'd0;
            exp_q.push_back(predict(opcode, funct3, funct7, bypass(rs1, rs1_data),
                bypass(rs2, rs2_data), imm, instr_addr, next_addr, is_reg_write, rd));
            mul_pending = is_mul;
            due_now = !is_mul;
            accepted++;
        end
    endtask

    initial begin
        rst = 1'b1;
        prev_stalled = 1'b1;
        opcode = op_imm;
        funct3 = 3'd0;
        funct7 = 7'd0;
        rd = 5'd0;
        rs1 = 5'd0;
        rs2 = 5'd0;
        rs1_data = '0;
        rs2_data = '0;
        imm = '0;
        instr_addr = '0;
        next_addr = '0;
        is_reg_write = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (accepted < num_instr || exp_q.size() != 0) begin
            check_cycle();
            offer_instr();
            @(negedge clk);
        end
        repeat (4) begin // drained, nothing more may retire.
            check_cycle();
            offer_instr();
            @(negedge clk);
        end
        $display("checks %0d, errors %0d, accepted %0d, retired %0d",
            checks, errors, accepted, retired);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verification
verilog/exec_pkg.sv
verilog/exec_int.sv
verilog/exec_branch.sv
verilog/exec_control.sv
verilog/exec_stage.sv
verification/exec_stage_tb.sv

// File: Makefile
# build and run the execute stage testbench with verilator

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f \
		--top-module exec_stage_tb -Mdir obj_dir -o exec_stage_sim
	./obj_dir/exec_stage_sim > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
